// File: src/matmul_sched_pkg.sv
// Scheduler widths, data types, default geometry, register addresses and FSM states
package matmul_sched_pkg;

  typedef logic [15:0] iter_t;
  typedef logic [7:0]  tile_dim_t;
  typedef logic [1:0]  cfg_addr_t;
  typedef logic [31:0] cfg_data_t;

  // Register map
  localparam cfg_addr_t CfgXIters    = 2'd0;
  localparam cfg_addr_t CfgWIters    = 2'd1;
  localparam cfg_addr_t CfgLeftovers = 2'd2;
  localparam cfg_addr_t CfgOpSel     = 2'd3;

  // Default array geometry
  localparam int unsigned DefHeight   = 4;
  localparam int unsigned DefWidth    = 8;
  localparam int unsigned DefDepth    = 8;
  localparam int unsigned DefPipeRegs = 3;

  typedef enum logic [1:0] {
    IdleS,
    PreloadS,
    LoadWS,
    WaitS
  } sched_state_e;

endpackage

// File: src/sched_cfg_regs.sv
// Configuration registers with iteration count, leftover and Y-enable fields
`timescale 1ns/1ps

module sched_cfg_regs
  import matmul_sched_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      start_i,
  input  logic      cfg_we_i,
  input  cfg_addr_t cfg_addr_i,
  input  cfg_data_t cfg_wdata_i,
  output iter_t     x_cols_iters_o,
  output iter_t     x_rows_iters_o,
  output iter_t     w_cols_iters_o,
  output iter_t     w_rows_iters_o,
  output tile_dim_t w_width_lo_o,
  output tile_dim_t w_height_lo_o,
  output tile_dim_t x_height_lo_o,
  output tile_dim_t x_width_lo_o,
  output logic      y_enable_o
);

  cfg_data_t x_iters_q, w_iters_q, leftovers_q;
  logic      y_enable_q;

  // Configuration survives a clear, but writes during a clear are dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_iters_q   <= '0;
      w_iters_q   <= '0;
      leftovers_q <= '0;
      y_enable_q  <= 1'b0;
    end else if (cfg_we_i && !clear_i) begin
      case (cfg_addr_i)
        CfgXIters:    x_iters_q   <= cfg_wdata_i;
        CfgWIters:    w_iters_q   <= cfg_wdata_i;
        CfgLeftovers: leftovers_q <= cfg_wdata_i;
        CfgOpSel:     y_enable_q  <= cfg_wdata_i[0];
      endcase
    end
  end

  assign x_cols_iters_o = x_iters_q[15:0];
  assign x_rows_iters_o = x_iters_q[31:16];
  assign w_cols_iters_o = w_iters_q[15:0];
  assign w_rows_iters_o = w_iters_q[31:16];
  assign w_width_lo_o   = leftovers_q[7:0];
  assign w_height_lo_o  = leftovers_q[15:8];
  assign x_height_lo_o  = leftovers_q[23:16];
  assign x_width_lo_o   = leftovers_q[31:24];
  assign y_enable_o     = y_enable_q;

  // Counters in all trackers wrap at count-1, so zero counts would never finish
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> (x_cols_iters_o != '0) && (x_rows_iters_o != '0) &&
                (w_cols_iters_o != '0) && (w_rows_iters_o != '0));

endmodule

// File: src/x_tile_tracker.sv
// X iteration counters, X reload and shift control, X tile sizes
`timescale 1ns/1ps

module x_tile_tracker
  import matmul_sched_pkg::*;
#(
  parameter int unsigned Height = DefHeight,
  parameter int unsigned Width  = DefWidth,
  parameter int unsigned Depth  = DefDepth
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      start_i,
  input  logic      x_empty_i,
  input  logic      x_full_i,
  input  logic      x_valid_i,
  input  logic      load_w_go_i,
  input  logic      preload_exit_i,
  input  iter_t     x_cols_iters_i,
  input  iter_t     x_rows_iters_i,
  input  iter_t     w_cols_iters_i,
  input  tile_dim_t x_height_lo_i,
  input  tile_dim_t x_width_lo_i,
  output logic      x_load_o,
  output logic      x_h_shift_o,
  output logic      x_d_shift_o,
  output logic      x_pad_setup_o,
  output logic      x_rst_w_index_o,
  output logic      x_shift_last_o,
  output tile_dim_t x_height_o,
  output tile_dim_t x_width_o
);

  localparam int unsigned ShiftW = (Height > 1) ? $clog2(Height) : 1;

  iter_t             x_cols_q, x_w_q, x_rows_q, x_rows_d;
  iter_t             x_cols_last, w_cols_last, x_rows_last;
  logic              x_w_en, x_rows_en, x_done_q, x_reload_q;
  logic [ShiftW-1:0] shift_cnt_q;

  assign x_cols_last = x_cols_iters_i - iter_t'(1);
  assign w_cols_last = w_cols_iters_i - iter_t'(1);
  assign x_rows_last = x_rows_iters_i - iter_t'(1);

  // Column -> weight pass -> row, stepped by each consumed X tile
  assign x_w_en    = x_empty_i && (x_cols_q == x_cols_last);
  assign x_rows_en = x_w_en && (x_w_q == w_cols_last);
  assign x_rows_d  = !x_rows_en ? x_rows_q : (x_rows_q == x_rows_last) ? '0 : x_rows_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_cols_q <= '0;
      x_w_q    <= '0;
      x_rows_q <= '0;
      x_done_q <= 1'b0;
    end else if (clear_i) begin
      x_cols_q <= '0;
      x_w_q    <= '0;
      x_rows_q <= '0;
      x_done_q <= 1'b0;
    end else if (!x_done_q) begin
      if (x_empty_i) begin
        x_cols_q <= x_w_en ? '0 : x_cols_q + 1'b1;
      end
      if (x_w_en) begin
        x_w_q <= x_rows_en ? '0 : x_w_q + 1'b1;
      end
      x_rows_q <= x_rows_d;
      x_done_q <= x_rows_en && (x_rows_q == x_rows_last);
    end
  end

  // Reload request is raised at start and on every drain, cleared once the buffer fills
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      x_reload_q  <= 1'b0;
      shift_cnt_q <= '0;
    end else if (clear_i) begin
      x_reload_q  <= 1'b0;
      shift_cnt_q <= '0;
    end else begin
      if (x_full_i) begin
        x_reload_q <= 1'b0;
      end else if (start_i || x_empty_i) begin
        x_reload_q <= 1'b1;
      end
      if (load_w_go_i) begin
        shift_cnt_q <= x_shift_last_o ? '0 : shift_cnt_q + 1'b1;
      end
    end
  end

  assign x_shift_last_o  = shift_cnt_q == ShiftW'(Height - 1);
  assign x_h_shift_o     = load_w_go_i;
  assign x_d_shift_o     = load_w_go_i && x_shift_last_o;
  assign x_rst_w_index_o = load_w_go_i && x_shift_last_o && x_full_i;
  assign x_pad_setup_o   = preload_exit_i;
  assign x_load_o        = (x_empty_i || x_reload_q) && x_valid_i;

  // Next-row value covers a width leftover of one
  assign x_height_o = (x_cols_q == x_cols_last && x_height_lo_i != '0) ?
                      x_height_lo_i : tile_dim_t'(Depth);
  assign x_width_o  = (x_rows_d == x_rows_last && x_width_lo_i != '0) ?
                      x_width_lo_i : tile_dim_t'(Width);

  // Depth shifts are horizontal shifts and come at most once per Height shifts
  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    x_d_shift_o |-> x_h_shift_o ##1 (!x_d_shift_o) [* Height - 1]);

endmodule

// File: src/w_tile_tracker.sv
// W iteration counters, W done flag, W tile sizes and buffer load and shift strobes
`timescale 1ns/1ps

module w_tile_tracker
  import matmul_sched_pkg::*;
#(
  parameter int unsigned Height      = DefHeight,
  parameter int unsigned Depth       = DefDepth,
  parameter int unsigned NumPipeRegs = DefPipeRegs
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      load_w_go_i,
  input  logic      in_wait_i,
  input  logic      w_valid_i,
  input  logic      stall_i,
  input  iter_t     w_rows_iters_i,
  input  iter_t     w_cols_iters_i,
  input  tile_dim_t w_height_lo_i,
  input  tile_dim_t w_width_lo_i,
  input  iter_t     x_rows_iters_i,
  output logic      w_load_o,
  output logic      w_shift_o,
  output tile_dim_t w_height_o,
  output tile_dim_t w_width_o,
  output logic      w_done_o,
  output logic      w_col_wrap_o
);

  iter_t w_rows_q, w_cols_q, w_mat_q;
  iter_t w_rows_last, w_cols_last, x_rows_last;
  logic  w_rows_en, w_mat_en, w_done_q, rows_near_end;

  assign w_rows_last = w_rows_iters_i - iter_t'(1);
  assign w_cols_last = w_cols_iters_i - iter_t'(1);
  assign x_rows_last = x_rows_iters_i - iter_t'(1);

  assign w_rows_en    = load_w_go_i && w_valid_i;
  assign w_col_wrap_o = w_rows_en && (w_rows_q == w_rows_last);
  assign w_mat_en     = w_col_wrap_o && (w_cols_q == w_cols_last);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_rows_q <= '0;
      w_cols_q <= '0;
      w_mat_q  <= '0;
      w_done_q <= 1'b0;
    end else if (clear_i) begin
      w_rows_q <= '0;
      w_cols_q <= '0;
      w_mat_q  <= '0;
      w_done_q <= 1'b0;
    end else if (!w_done_q) begin
      if (w_rows_en) begin
        w_rows_q <= w_col_wrap_o ? '0 : w_rows_q + 1'b1;
      end
      if (w_col_wrap_o) begin
        w_cols_q <= w_mat_en ? '0 : w_cols_q + 1'b1;
      end
      if (w_mat_en) begin
        w_mat_q <= w_mat_q + 1'b1;
      end
      // One W matrix per X row block
      w_done_q <= w_mat_en && (w_mat_q == x_rows_last);
    end
  end

  // The height switches early so the rows still in the pipeline see it
  assign rows_near_end = (32'(w_rows_q) + NumPipeRegs + 1) >= 32'(w_rows_iters_i);

  assign w_height_o = (rows_near_end && w_height_lo_i != '0) ? w_height_lo_i : tile_dim_t'(Height);
  assign w_width_o  = (w_cols_q == w_cols_last && w_width_lo_i != '0) ?
                      w_width_lo_i : tile_dim_t'(Depth);

  assign w_done_o  = w_done_q;
  assign w_load_o  = load_w_go_i;
  assign w_shift_o = load_w_go_i || (in_wait_i && !stall_i);

endmodule

// File: src/z_drain_ctrl.sv
// Z pipeline wait, Y push and Z fill windows, Y/Z iteration counters and Z tile sizes
`timescale 1ns/1ps

module z_drain_ctrl
  import matmul_sched_pkg::*;
#(
  parameter int unsigned Width       = DefWidth,
  parameter int unsigned Depth       = DefDepth,
  parameter int unsigned NumPipeRegs = DefPipeRegs
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  input  logic      stall_i,
  input  logic      w_col_wrap_i,
  input  logic      start_comp_i,
  input  logic      z_empty_i,
  input  iter_t     w_rows_iters_i,
  input  iter_t     w_cols_iters_i,
  input  tile_dim_t w_height_lo_i,
  input  tile_dim_t w_width_lo_i,
  output logic      y_push_o,
  output logic      z_fill_o,
  output logic      z_first_load_o,
  output logic      z_wait_last_o,
  output tile_dim_t z_width_o,
  output tile_dim_t z_height_o
);

  localparam int unsigned WaitW = $clog2(NumPipeRegs + 1);

  logic [WaitW-1:0] wait_q;
  tile_dim_t        fill_q, push_q, y_width, y_height, z_width_q, z_height_q;
  iter_t            y_cols_q, y_rows_q, w_cols_last, w_rows_last;
  logic             wait_en_q, fill_en_q, push_en_q;
  logic             wait_clr, fill_clr, push_clr, push_set, y_cols_wrap;

  assign w_cols_last = w_cols_iters_i - iter_t'(1);
  assign w_rows_last = w_rows_iters_i - iter_t'(1);

  assign z_wait_last_o = wait_q == WaitW'(NumPipeRegs);
  assign wait_clr      = wait_en_q && !stall_i && z_wait_last_o;
  assign fill_clr      = fill_en_q && !stall_i && (fill_q == z_height_q - 1'b1);
  assign push_clr      = push_en_q && !stall_i && (push_q == y_height - 1'b1);
  // Y push leads the Z fill by one cycle
  assign push_set      = (wait_en_q && !stall_i && wait_q == WaitW'(NumPipeRegs - 1)) ||
                         start_comp_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_en_q <= 1'b0;
      fill_en_q <= 1'b0;
      push_en_q <= 1'b0;
      wait_q    <= '0;
      fill_q    <= '0;
      push_q    <= '0;
    end else if (clear_i) begin
      wait_en_q <= 1'b0;
      fill_en_q <= 1'b0;
      push_en_q <= 1'b0;
      wait_q    <= '0;
      fill_q    <= '0;
      push_q    <= '0;
    end else begin
      wait_en_q <= !wait_clr && (wait_en_q || w_col_wrap_i);
      fill_en_q <= !fill_clr && (fill_en_q || wait_clr);
      push_en_q <= !push_clr && (push_en_q || push_set);
      if (wait_en_q && !stall_i) begin
        wait_q <= z_wait_last_o ? '0 : wait_q + 1'b1;
      end
      if (fill_en_q && !stall_i) begin
        fill_q <= fill_clr ? '0 : fill_q + 1'b1;
      end
      if (push_en_q && !stall_i) begin
        push_q <= push_clr ? '0 : push_q + 1'b1;
      end
    end
  end

  assign y_cols_wrap = y_cols_q == w_cols_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      y_cols_q   <= '0;
      y_rows_q   <= '0;
      z_width_q  <= '0;
      z_height_q <= '0;
    end else if (clear_i) begin
      y_cols_q   <= '0;
      y_rows_q   <= '0;
      z_width_q  <= '0;
      z_height_q <= '0;
    end else begin
      if (z_empty_i) begin
        y_cols_q <= y_cols_wrap ? '0 : y_cols_q + 1'b1;
      end
      if (z_empty_i && y_cols_wrap) begin
        y_rows_q <= (y_rows_q == w_rows_last) ? '0 : y_rows_q + 1'b1;
      end
      // Sizes of the tile now being drained
      if (z_empty_i || start_comp_i) begin
        z_width_q  <= y_width;
        z_height_q <= y_height;
      end
    end
  end

  assign y_width  = (y_rows_q == w_rows_last && w_height_lo_i != '0) ?
                    w_height_lo_i : tile_dim_t'(Width);
  assign y_height = (y_cols_wrap && w_width_lo_i != '0) ? w_width_lo_i : tile_dim_t'(Depth);

  assign y_push_o       = push_en_q && !stall_i;
  assign z_fill_o       = fill_en_q && !stall_i;
  assign z_first_load_o = (y_cols_q == '0) && (y_rows_q == '0);
  assign z_width_o      = z_width_q;
  assign z_height_o     = z_height_q;

endmodule

// File: src/sched_fsm.sv
// Scheduler FSM with stall checks, wait counter, status flags and engine enables
`timescale 1ns/1ps

module sched_fsm
  import matmul_sched_pkg::*;
#(
  parameter int unsigned Width       = DefWidth,
  parameter int unsigned NumPipeRegs = DefPipeRegs
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             start_i,
  input  logic             x_full_i,
  input  logic             x_empty_i,
  input  logic             y_loaded_i,
  input  logic             w_valid_i,
  input  logic             y_enable_i,
  input  logic             w_done_i,
  input  logic             x_shift_last_i,
  input  logic             x_rst_w_index_i,
  input  logic             z_wait_last_i,
  input  logic             y_push_i,
  input  tile_dim_t        z_width_i,
  output logic             load_w_go_o,
  output logic             in_wait_o,
  output logic             preload_exit_o,
  output logic             start_comp_o,
  output logic             stall_o,
  output logic             reg_enable_o,
  output logic             accumulate_o,
  output logic [Width-1:0] row_gate_o
);

  localparam int unsigned WaitW = $clog2(NumPipeRegs + 1);

  sched_state_e     state_q, state_d;
  logic [WaitW-1:0] wait_q;
  logic             wait_last;
  logic             first_load_q, computing_q, x_refill_q, pushing_y_q;

  assign wait_last = wait_q == WaitW'(NumPipeRegs);

  // Hold load-W until the next W row, the X refill and the Y rows are ready
  assign stall_o = (state_q == LoadWS) && (
                     (!w_valid_i && !w_done_i) ||
                     (!x_full_i && x_refill_q && x_shift_last_i) ||
                     (!y_loaded_i && z_wait_last_i && !w_done_i));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IdleS: begin
        if (start_i) begin
          state_d = PreloadS;
        end
      end
      PreloadS: begin
        if (x_full_i && (y_loaded_i || !y_enable_i)) begin
          state_d = LoadWS;
        end
      end
      LoadWS: begin
        if (!stall_o) begin
          state_d = WaitS;
        end
      end
      WaitS: begin
        if (wait_last) begin
          state_d = LoadWS;
        end
      end
      default: state_d = IdleS;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IdleS;
      wait_q       <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
      x_refill_q   <= 1'b0;
      pushing_y_q  <= 1'b0;
    end else if (clear_i) begin
      state_q      <= IdleS;
      wait_q       <= '0;
      first_load_q <= 1'b1;
      computing_q  <= 1'b0;
      x_refill_q   <= 1'b0;
      pushing_y_q  <= 1'b0;
    end else begin
      state_q     <= state_d;
      pushing_y_q <= y_push_i;
      // Runs through load-W and wait, NumPipeRegs+1 steps per W row
      if (!stall_o && (state_q == LoadWS || state_q == WaitS)) begin
        wait_q <= wait_last ? '0 : wait_q + 1'b1;
      end
      if (load_w_go_o) begin
        first_load_q <= 1'b0;
      end
      if (preload_exit_o) begin
        computing_q <= 1'b1;
      end
      if (x_rst_w_index_i) begin
        x_refill_q <= 1'b0;
      end else if (x_empty_i) begin
        x_refill_q <= 1'b1;
      end
    end
  end

  assign load_w_go_o    = (state_q == LoadWS) && !stall_o;
  assign in_wait_o      = state_q == WaitS;
  assign preload_exit_o = (state_q == PreloadS) && (state_d == LoadWS);
  assign start_comp_o   = first_load_q && (state_d == LoadWS) && !stall_o;
  assign reg_enable_o   = computing_q && !stall_o;
  assign accumulate_o   = !pushing_y_q;

  // Only the rows of the current Z tile are clocked
  always_comb begin
    for (int i = 0; i < Width; i++) begin
      row_gate_o[i] = reg_enable_o && (tile_dim_t'(i) < z_width_i);
    end
  end

  // A stall only holds at the start of a W row, with the wait counter at zero
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_o |-> (wait_q == '0));

endmodule

// File: src/matmul_sched_top.sv
// Tile scheduler top with the config registers, X/W trackers, Z drain and FSM
`timescale 1ns/1ps

module matmul_sched_top
  import matmul_sched_pkg::*;
#(
  parameter int unsigned Height      = DefHeight,
  parameter int unsigned Width       = DefWidth,
  parameter int unsigned Depth       = DefDepth,
  parameter int unsigned NumPipeRegs = DefPipeRegs
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             start_i,
  input  logic             cfg_we_i,
  input  cfg_addr_t        cfg_addr_i,
  input  cfg_data_t        cfg_wdata_i,
  input  logic             x_empty_i,
  input  logic             x_full_i,
  input  logic             x_valid_i,
  input  logic             w_valid_i,
  input  logic             y_loaded_i,
  input  logic             z_empty_i,
  output logic             x_load_o,
  output logic             x_h_shift_o,
  output logic             x_d_shift_o,
  output logic             x_pad_setup_o,
  output logic             x_rst_w_index_o,
  output tile_dim_t        x_height_o,
  output tile_dim_t        x_width_o,
  output logic             w_load_o,
  output logic             w_shift_o,
  output tile_dim_t        w_height_o,
  output tile_dim_t        w_width_o,
  output logic             y_push_o,
  output logic             z_fill_o,
  output logic             z_first_load_o,
  output tile_dim_t        z_width_o,
  output tile_dim_t        z_height_o,
  output logic             reg_enable_o,
  output logic             accumulate_o,
  output logic [Width-1:0] row_gate_o
);

  iter_t     x_cols_iters, x_rows_iters, w_cols_iters, w_rows_iters;
  tile_dim_t w_width_lo, w_height_lo, x_height_lo, x_width_lo;
  logic      y_enable, load_w_go, in_wait, preload_exit, start_comp, stall;
  logic      x_shift_last, w_done, w_col_wrap, z_wait_last;

  sched_cfg_regs u_cfg (
    .clk_i, .rst_ni, .clear_i, .start_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
    .x_cols_iters_o (x_cols_iters), .x_rows_iters_o (x_rows_iters),
    .w_cols_iters_o (w_cols_iters), .w_rows_iters_o (w_rows_iters),
    .w_width_lo_o   (w_width_lo),   .w_height_lo_o  (w_height_lo),
    .x_height_lo_o  (x_height_lo),  .x_width_lo_o   (x_width_lo),
    .y_enable_o     (y_enable)
  );

  x_tile_tracker #(.Height(Height), .Width(Width), .Depth(Depth)) u_x (
    .clk_i, .rst_ni, .clear_i, .start_i, .x_empty_i, .x_full_i, .x_valid_i,
    .load_w_go_i    (load_w_go),    .preload_exit_i (preload_exit),
    .x_cols_iters_i (x_cols_iters), .x_rows_iters_i (x_rows_iters),
    .w_cols_iters_i (w_cols_iters), .x_height_lo_i  (x_height_lo),
    .x_width_lo_i   (x_width_lo),
    .x_load_o, .x_h_shift_o, .x_d_shift_o, .x_pad_setup_o, .x_rst_w_index_o,
    .x_shift_last_o (x_shift_last), .x_height_o, .x_width_o
  );

  w_tile_tracker #(.Height(Height), .Depth(Depth), .NumPipeRegs(NumPipeRegs)) u_w (
    .clk_i, .rst_ni, .clear_i, .w_valid_i,
    .load_w_go_i    (load_w_go),    .in_wait_i      (in_wait),      .stall_i (stall),
    .w_rows_iters_i (w_rows_iters), .w_cols_iters_i (w_cols_iters),
    .w_height_lo_i  (w_height_lo),  .w_width_lo_i   (w_width_lo),
    .x_rows_iters_i (x_rows_iters),
    .w_load_o, .w_shift_o, .w_height_o, .w_width_o,
    .w_done_o       (w_done),       .w_col_wrap_o   (w_col_wrap)
  );

  z_drain_ctrl #(.Width(Width), .Depth(Depth), .NumPipeRegs(NumPipeRegs)) u_z (
    .clk_i, .rst_ni, .clear_i, .z_empty_i,
    .stall_i        (stall),        .w_col_wrap_i   (w_col_wrap),
    .start_comp_i   (start_comp),
    .w_rows_iters_i (w_rows_iters), .w_cols_iters_i (w_cols_iters),
    .w_height_lo_i  (w_height_lo),  .w_width_lo_i   (w_width_lo),
    .y_push_o, .z_fill_o, .z_first_load_o,
    .z_wait_last_o  (z_wait_last),  .z_width_o, .z_height_o
  );

  sched_fsm #(.Width(Width), .NumPipeRegs(NumPipeRegs)) u_fsm (
    .clk_i, .rst_ni, .clear_i, .start_i, .x_full_i, .x_empty_i, .y_loaded_i, .w_valid_i,
    .y_enable_i      (y_enable),        .w_done_i       (w_done),
    .x_shift_last_i  (x_shift_last),    .x_rst_w_index_i (x_rst_w_index_o),
    .z_wait_last_i   (z_wait_last),     .y_push_i       (y_push_o),
    .z_width_i       (z_width_o),
    .load_w_go_o     (load_w_go),       .in_wait_o      (in_wait),
    .preload_exit_o  (preload_exit),    .start_comp_o   (start_comp),
    .stall_o         (stall),
    .reg_enable_o, .accumulate_o, .row_gate_o
  );

endmodule

// File: test/tb_matmul_sched.sv
// Table-driven testbench for the tile scheduler with compare tasks and a cycle limit
`timescale 1ns/1ps

module tb_matmul_sched
  import matmul_sched_pkg::*;
();

  localparam int unsigned Height        = DefHeight;
  localparam int unsigned Width         = DefWidth;
  localparam int unsigned Depth         = DefDepth;
  localparam int unsigned NumPipeRegs   = DefPipeRegs;
  localparam int unsigned NumTests      = 3;
  localparam int unsigned TimeoutCycles = NumTests * 200;

  logic             clk_i = 1'b0;
  logic             rst_ni;
  logic             clear_i;
  logic             start_i;
  logic             cfg_we_i;
  cfg_addr_t        cfg_addr_i;
  cfg_data_t        cfg_wdata_i;
  logic             x_empty_i;
  logic             x_full_i;
  logic             x_valid_i;
  logic             w_valid_i;
  logic             y_loaded_i;
  logic             z_empty_i;
  logic             x_load_o;
  logic             x_h_shift_o;
  logic             x_d_shift_o;
  logic             x_pad_setup_o;
  logic             x_rst_w_index_o;
  tile_dim_t        x_height_o;
  tile_dim_t        x_width_o;
  logic             w_load_o;
  logic             w_shift_o;
  tile_dim_t        w_height_o;
  tile_dim_t        w_width_o;
  logic             y_push_o;
  logic             z_fill_o;
  logic             z_first_load_o;
  tile_dim_t        z_width_o;
  tile_dim_t        z_height_o;
  logic             reg_enable_o;
  logic             accumulate_o;
  logic [Width-1:0] row_gate_o;

  // Iteration words hold rows in the high half, leftovers are W width, W height, X height, X width
  string       tbl_name      [NumTests] = '{"lo_no_y", "no_lo_y", "tall_w"};
  cfg_data_t   tbl_x_iters   [NumTests] = '{32'h0004_0003, 32'h0004_0004, 32'h0008_0002};
  cfg_data_t   tbl_w_iters   [NumTests] = '{32'h0002_0003, 32'h0002_0004, 32'h0006_0002};
  cfg_data_t   tbl_leftovers [NumTests] = '{32'h0006_0005, 32'h0000_0000, 32'h0401_0203};
  cfg_data_t   tbl_op_sel    [NumTests] = '{32'h0, 32'h1, 32'h1};
  int unsigned tbl_stall_max [NumTests] = '{6, 9, 12};
  tile_dim_t   tbl_x_height  [NumTests] = '{8'd6, 8'd8, 8'd1};
  tile_dim_t   tbl_w_width   [NumTests] = '{8'd5, 8'd8, 8'd3};
  iter_t       tbl_spacing   [NumTests] = '{16'd4, 16'd4, 16'd4};

  string       cur_name;
  int unsigned h_shift_cnt  = 0;
  int unsigned w_load_cnt   = 0;
  int unsigned w_target     = 0;
  tile_dim_t   w_width_exp;
  logic        w_width_seen = 1'b1;
  int unsigned cycle_cnt    = 0;

  matmul_sched_top #(
    .Height      (Height),
    .Width       (Width),
    .Depth       (Depth),
    .NumPipeRegs (NumPipeRegs)
  ) dut0 (
    .clk_i, .rst_ni, .clear_i, .start_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
    .x_empty_i, .x_full_i, .x_valid_i, .w_valid_i, .y_loaded_i, .z_empty_i,
    .x_load_o, .x_h_shift_o, .x_d_shift_o, .x_pad_setup_o, .x_rst_w_index_o,
    .x_height_o, .x_width_o, .w_load_o, .w_shift_o, .w_height_o, .w_width_o,
    .y_push_o, .z_fill_o, .z_first_load_o, .z_width_o, .z_height_o,
    .reg_enable_o, .accumulate_o, .row_gate_o
  );

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("TEST FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("mismatch test %s %s: expected %0b actual %0b", cur_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_dim(input string what, input tile_dim_t exp, input tile_dim_t act);
    if (act !== exp) begin
      $display("mismatch test %s %s: expected %0d actual %0d", cur_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string what, input iter_t exp, input iter_t act);
    if (act !== exp) begin
      $display("mismatch test %s %s: expected %0d actual %0d", cur_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  // Falling edge sample, every Height-th shift is also a depth shift
  task automatic sample_cycle();
    logic d_exp;
    @(negedge clk_i);
    d_exp = (x_h_shift_o === 1'b1) && (h_shift_cnt % Height == Height - 1);
    check_bit("x_d_shift_o", d_exp, x_d_shift_o);
    // A depth shift into a full X buffer restarts the W index
    check_bit("x_rst_w_index_o", d_exp && (x_full_i === 1'b1), x_rst_w_index_o);
    if (x_h_shift_o === 1'b1) begin
      h_shift_cnt++;
    end
    // W width after the loads that reach the last W column
    if (!w_width_seen && w_load_cnt == w_target) begin
      check_dim("w_width_o", w_width_exp, w_width_o);
      w_width_seen = 1'b1;
    end
    if (w_load_o === 1'b1) begin
      w_load_cnt++;
    end
  endtask

  task automatic check_idle();
    check_bit("w_load_o", 1'b0, w_load_o);
    check_bit("x_h_shift_o", 1'b0, x_h_shift_o);
    check_bit("y_push_o", 1'b0, y_push_o);
    check_bit("z_fill_o", 1'b0, z_fill_o);
    check_bit("reg_enable_o", 1'b0, reg_enable_o);
    check_bit("x_load_o", 1'b0, x_load_o);
    check_bit("accumulate_o", 1'b1, accumulate_o);
    check_bit("z_first_load_o", 1'b1, z_first_load_o);
    check_bit("row_gate_o", 1'b0, |row_gate_o);
  endtask

  task automatic check_preload_held();
    sample_cycle();
    check_bit("w_load_o", 1'b0, w_load_o);
    check_bit("x_pad_setup_o", 1'b0, x_pad_setup_o);
    // X reload stays requested until the buffer reports full
    if (x_full_i === 1'b0) begin
      check_bit("x_load_o", 1'b1, x_load_o);
    end
    next_cycle();
  endtask

  initial begin
    int unsigned stall_len;
    iter_t       gap;
    stall_len   = $urandom(84);
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    start_i     = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    x_empty_i   = 1'b0;
    x_full_i    = 1'b0;
    x_valid_i   = 1'b1;
    w_valid_i   = 1'b1;
    y_loaded_i  = 1'b0;
    z_empty_i   = 1'b0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    for (int t = 0; t < NumTests; t++) begin
      next_cycle();
      clear_i    = 1'b1;
      x_full_i   = 1'b0;
      y_loaded_i = 1'b0;
      w_valid_i  = 1'b1;
      sample_cycle();
      next_cycle();
      clear_i      = 1'b0;
      cur_name     = tbl_name[t];
      h_shift_cnt  = 0;
      w_load_cnt   = 0;
      w_target     = tbl_w_iters[t][31:16] * (tbl_w_iters[t][15:0] - 1);
      w_width_exp  = tbl_w_width[t];
      w_width_seen = 1'b0;

      // Idle with register writes, nothing moves without a start
      for (int i = 0; i < 6; i++) begin
        cfg_we_i    = (i < 4);
        cfg_addr_i  = cfg_addr_t'(i);
        cfg_wdata_i = (i == 0) ? tbl_x_iters[t] : (i == 1) ? tbl_w_iters[t] :
                      (i == 2) ? tbl_leftovers[t] : tbl_op_sel[t];
        sample_cycle();
        check_idle();
        next_cycle();
      end
      cfg_we_i = 1'b0;

      start_i = 1'b1;
      sample_cycle();
      // The first X row is not the last one, so it has the full width
      if (tbl_x_iters[t][31:16] > 1) begin
        check_dim("x_width_o", tile_dim_t'(Width), x_width_o);
      end
      if (tbl_leftovers[t][15:8] == 8'd0) begin
        check_dim("w_height_o", tile_dim_t'(Height), w_height_o);
      end
      next_cycle();
      start_i = 1'b0;
      repeat (3) check_preload_held();
      x_full_i = 1'b1;
      if (tbl_op_sel[t][0]) begin
        repeat (3) check_preload_held();
        y_loaded_i = 1'b1;
      end
      sample_cycle();
      check_bit("x_pad_setup_o", 1'b1, x_pad_setup_o);
      check_bit("w_load_o", 1'b0, w_load_o);
      next_cycle();
      y_loaded_i = 1'b1;
      sample_cycle();
      check_bit("w_load_o", 1'b1, w_load_o);
      check_bit("x_pad_setup_o", 1'b0, x_pad_setup_o);
      check_bit("w_shift_o", 1'b1, w_shift_o);
      // First Z tile of a multi-tile matrix takes the full array size
      check_dim("z_width_o", tile_dim_t'(Width), z_width_o);
      check_dim("z_height_o", tile_dim_t'(Depth), z_height_o);

      // Free-running loads
      repeat (3) begin
        gap = '0;
        do begin
          next_cycle();
          sample_cycle();
          gap = gap + 1'b1;
          check_bit("w_shift_o", 1'b1, w_shift_o);
        end while (w_load_o !== 1'b1);
        check_count("load spacing", tbl_spacing[t], gap);
      end

      // W stall starting in the next load-W cycle
      stall_len = 1 + ($urandom % tbl_stall_max[t]);
      repeat (NumPipeRegs) begin
        next_cycle();
        sample_cycle();
      end
      next_cycle();
      w_valid_i = 1'b0;
      repeat (stall_len) begin
        sample_cycle();
        check_bit("w_load_o", 1'b0, w_load_o);
        check_bit("reg_enable_o", 1'b0, reg_enable_o);
        check_bit("x_h_shift_o", 1'b0, x_h_shift_o);
        check_bit("w_shift_o", 1'b0, w_shift_o);
        check_bit("row_gate_o", 1'b0, |row_gate_o);
        next_cycle();
      end
      w_valid_i = 1'b1;
      sample_cycle();
      check_bit("w_load_o", 1'b1, w_load_o);
      check_bit("reg_enable_o", 1'b1, reg_enable_o);
      check_bit("row_gate_o", 1'b1, &row_gate_o);

      // Consumed X tiles up to the last column
      if (tbl_x_iters[t][15:0] > 1) begin
        check_dim("x_height_o", tile_dim_t'(Depth), x_height_o);
      end
      repeat (tbl_x_iters[t][15:0] - 1) begin
        next_cycle();
        x_empty_i = 1'b1;
        sample_cycle();
        next_cycle();
        x_empty_i = 1'b0;
        sample_cycle();
      end
      check_dim("x_height_o", tbl_x_height[t], x_height_o);

      while (!w_width_seen) begin
        next_cycle();
        sample_cycle();
      end
    end

    $display("TEST OK");
    $finish;
  end

endmodule

// File: matmul_sched.f
src/matmul_sched_pkg.sv
src/sched_cfg_regs.sv
src/x_tile_tracker.sv
src/w_tile_tracker.sv
src/z_drain_ctrl.sv
src/sched_fsm.sv
src/matmul_sched_top.sv
test/tb_matmul_sched.sv

// File: Bender.yml
package:
  name: matmul_sched

sources:
  - files:
      - src/matmul_sched_pkg.sv
      - src/sched_cfg_regs.sv
      - src/x_tile_tracker.sv
      - src/w_tile_tracker.sv
      - src/z_drain_ctrl.sv
      - src/sched_fsm.sv
      - src/matmul_sched_top.sv
  - target: test
    files:
      - test/tb_matmul_sched.sv
